/* source/chroni_pkg.sv */
`default_nettype none

package chroni_pkg;

   typedef enum logic [1:0] {
      mode_640x480   = 2'd0,
      mode_800x600   = 2'd1,
      mode_1920x1080 = 2'd2
   } vga_mode_t;

   // counters run from 1, so every position below is 1-based
   typedef struct packed {
      logic [11:0] h_sync_end;
      logic [11:0] h_total;
      logic [11:0] h_de_start;
      logic [11:0] h_de_end;
      logic [11:0] h_pf_start;
      logic [11:0] h_pf_end;
      logic [11:0] v_sync_end;
      logic [11:0] v_total;
      logic [11:0] v_de_start;
      logic [11:0] v_de_end;
      logic [11:0] v_pf_start;
      logic [11:0] v_pf_end;
      logic        h_sync_pol;
      logic        v_sync_pol;
   } timing_t;

   typedef logic [15:0] pixel_t;

   localparam timing_t timing_640 = '{
      h_sync_end: 12'd97,  h_total: 12'd800,  h_de_start: 12'd145,
      h_de_end: 12'd785,   h_pf_start: 12'd177, h_pf_end: 12'd753,
      v_sync_end: 12'd3,   v_total: 12'd525,  v_de_start: 12'd36,
      v_de_end: 12'd516,   v_pf_start: 12'd60,  v_pf_end: 12'd492,
      h_sync_pol: 1'b0,    v_sync_pol: 1'b0
   };

   localparam timing_t timing_800 = '{
      h_sync_end: 12'd129, h_total: 12'd1056, h_de_start: 12'd217,
      h_de_end: 12'd1017,  h_pf_start: 12'd297, h_pf_end: 12'd937,
      v_sync_end: 12'd5,   v_total: 12'd628,  v_de_start: 12'd28,
      v_de_end: 12'd628,   v_pf_start: 12'd88,  v_pf_end: 12'd568,
      h_sync_pol: 1'b1,    v_sync_pol: 1'b1
   };

   // playfield is 640x360 source pixels shown at twice the size
   localparam timing_t timing_1080 = '{
      h_sync_end: 12'd45,  h_total: 12'd2200, h_de_start: 12'd193,
      h_de_end: 12'd2113,  h_pf_start: 12'd513, h_pf_end: 12'd1793,
      v_sync_end: 12'd6,   v_total: 12'd1125, v_de_start: 12'd42,
      v_de_end: 12'd1122,  v_pf_start: 12'd222, v_pf_end: 12'd942,
      h_sync_pol: 1'b1,    v_sync_pol: 1'b1
   };

   // indexed by mode code
   localparam logic [3:0] scale_1080 = 4'b0100;

   localparam logic [10:0] buffer_half = 11'd640;
   localparam logic [11:0] pf_prefetch = 12'd4;
   localparam logic [11:0] render_lead = 12'd2;

endpackage

`default_nettype wire

/* source/event_crossing.sv */
`timescale 1ns/1ns
`default_nettype none

module event_crossing (
   input  logic src_clk,
   input  logic dst_clk,
   input  logic reset_n,
   input  logic src_req,
   output logic busy,
   output logic pulse
);

   logic       req;
   logic [1:0] req_sync;
   logic       req_seen;
   logic [1:0] ack_sync;

   // source side holds req until the ack comes back
   always_ff @(posedge src_clk) begin
      if (!reset_n) begin
         req      <= 1'b0;
         ack_sync <= 2'b00;
      end else begin
         ack_sync <= {ack_sync[0], req_sync[1]};
         if (src_req) req <= 1'b1;
         else if (ack_sync[1]) req <= 1'b0;
      end
   end

   // busy until the ack has dropped as well
   assign busy = req || ack_sync[1];

   always_ff @(posedge dst_clk) begin
      if (!reset_n) begin
         req_sync <= 2'b00;
         req_seen <= 1'b0;
         pulse    <= 1'b0;
      end else begin
         req_sync <= {req_sync[0], req};
         req_seen <= req_sync[1];
         pulse    <= req_sync[1] && !req_seen;
      end
   end

endmodule

`default_nettype wire

/* source/level_sync.sv */
`timescale 1ns/1ns
`default_nettype none

module level_sync #(
   parameter type payload_t = logic
) (
   input  logic     dst_clk,
   input  payload_t d,
   output payload_t q
);

   payload_t meta;

   // slow levels only, bits may land a cycle apart
   always_ff @(posedge dst_clk) begin
      meta <= d;
      q    <= meta;
   end

endmodule

`default_nettype wire

/* source/line_output.sv */
`timescale 1ns/1ns
`default_nettype none

module line_output (
   input  logic               vga_clk,
   input  logic               reset_n,
   raster_if.out              rif,
   input  logic               scale,
   input  logic               double_active,
   input  logic               line_phase,
   input  logic               blank_scanline,
   input  logic               read_text,
   input  logic               read_font,
   input  chroni_pkg::pixel_t pixel,
   input  chroni_pkg::pixel_t border_color,
   output logic [10:0]        buffer_index,
   output logic [4:0]         r,
   output logic [5:0]         g,
   output logic [4:0]         b
);

   logic [1:0]         rep_cnt;
   logic [1:0]         rep_last;
   logic               show_line;
   logic               in_de;
   logic               in_pf;
   chroni_pkg::pixel_t shown;

   // cycles per buffer entry minus one: 1, 2 or 4 cycles
   always_comb begin
      if (double_active) begin
         rep_last = scale ? 2'd3 : 2'd1;
      end else begin
         rep_last = scale ? 2'd1 : 2'd0;
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         rep_cnt      <= 2'd0;
         buffer_index <= 11'd0;
      end else if (rif.h_pf_pix && rif.v_pf) begin
         if (rep_cnt == rep_last) begin
            rep_cnt      <= 2'd0;
            buffer_index <= buffer_index + 11'd1;
         end else begin
            rep_cnt <= rep_cnt + 2'd1;
         end
      end else begin
         rep_cnt      <= 2'd0;
         buffer_index <= line_phase ? chroni_pkg::buffer_half : 11'd0;
      end
   end

   // blanking applies to the whole next line
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         show_line <= 1'b1;
      end else if (rif.scanline_end) begin
         show_line <= !blank_scanline;
      end
   end

   assign in_de = rif.h_de && rif.v_de;
   assign in_pf = rif.h_pf && rif.v_pf && show_line;
   assign shown = in_pf ? pixel : border_color;

   // text and font reads force red and green high for debug
   assign r = !in_de ? 5'd0 : (read_text ? 5'h1f : shown[15:11]);
   assign g = !in_de ? 6'd0 : (read_font ? 6'h3f : shown[10:5]);
   assign b = !in_de ? 5'd0 : shown[4:0];

endmodule

`default_nettype wire

/* source/mode_control.sv */
`timescale 1ns/1ns
`default_nettype none

module mode_control (
   input  logic                  vga_clk,
   input  logic                  reset_n,
   input  chroni_pkg::vga_mode_t mode_req,
   input  logic                  double_pixel,
   raster_if.control             rif,
   output chroni_pkg::timing_t   timing,
   output logic                  mode_reload,
   output logic                  scale,
   output logic                  double_active,
   output logic                  line_phase,
   output logic                  frame_req,
   output logic                  render_req,
   output logic                  scanline_req,
   output logic                  changed_req,
   input  logic                  frame_busy,
   input  logic                  render_busy,
   input  logic                  scanline_busy,
   input  logic                  changed_busy
);

   chroni_pkg::vga_mode_t mode;
   logic       load;
   logic       odd_line;
   logic       phase_run;
   logic [2:0] phase_cnt;
   logic [2:0] phase_half;
   logic [2:0] phase_last;

   // switch only at frame start, once the last change notice got through
   assign load = rif.frame_tick && (mode_req != mode) && !changed_busy;

   assign phase_half = scale ? 3'd3 : 3'd1;
   assign phase_last = scale ? 3'd7 : 3'd3;

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         mode        <= chroni_pkg::mode_640x480;
         timing      <= chroni_pkg::timing_640;
         scale       <= 1'b0;
         mode_reload <= 1'b0;
         changed_req <= 1'b0;
      end else begin
         mode_reload <= load;
         changed_req <= load;
         if (load) begin
            mode  <= mode_req;
            scale <= chroni_pkg::scale_1080[mode_req];
            case (mode_req)
               chroni_pkg::mode_800x600:   timing <= chroni_pkg::timing_800;
               chroni_pkg::mode_1920x1080: timing <= chroni_pkg::timing_1080;
               default:                    timing <= chroni_pkg::timing_640;
            endcase
         end
      end
   end

   // the restart after a reload brings its own frame tick
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         frame_req     <= 1'b0;
         render_req    <= 1'b0;
         scanline_req  <= 1'b0;
         odd_line      <= 1'b0;
         double_active <= 1'b0;
      end else begin
         frame_req    <= rif.frame_tick && !load && !frame_busy;
         render_req   <= rif.scanline_end && !render_busy &&
                         (rif.y == timing.v_pf_start - chroni_pkg::render_lead);
         scanline_req <= rif.scanline_end && odd_line && !scanline_busy;
         if (rif.scanline_end) begin
            odd_line      <= !odd_line;
            double_active <= double_pixel;
         end
      end
   end

   // buffer half alternates every 2 lines, or 4 when scaled
   always_ff @(posedge vga_clk) begin
      if (!reset_n || mode_reload) begin
         phase_run  <= 1'b0;
         phase_cnt  <= 3'd0;
         line_phase <= 1'b0;
      end else if (rif.scanline_end) begin
         if (rif.y == timing.v_pf_end) begin
            phase_run <= 1'b0;
         end else if (rif.y == timing.v_pf_start - 12'd1) begin
            phase_run  <= 1'b1;
            phase_cnt  <= 3'd0;
            line_phase <= 1'b0;
         end else if (phase_run) begin
            phase_cnt <= (phase_cnt == phase_last) ? 3'd0 : phase_cnt + 3'd1;
            if (phase_cnt == phase_half) begin
               line_phase <= 1'b1;
            end else if (phase_cnt == phase_last) begin
               line_phase <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* source/raster_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module raster_counter (
   input  logic                vga_clk,
   input  logic                reset_n,
   input  chroni_pkg::timing_t timing,
   input  logic                mode_reload,
   raster_if.counter           rif,
   output logic                hs,
   output logic                vs
);

   logic hs_act;
   logic vs_act;

   always_ff @(posedge vga_clk) begin
      if (!reset_n || mode_reload) begin
         rif.x <= 12'd1;
         rif.y <= 12'd1;
      end else if (rif.scanline_end) begin
         rif.x <= 12'd1;
         rif.y <= (rif.y == timing.v_total) ? 12'd1 : rif.y + 12'd1;
      end else begin
         rif.x <= rif.x + 12'd1;
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n || mode_reload) begin
         rif.scanline_end <= 1'b0;
         rif.frame_tick   <= 1'b0;
         hs_act           <= 1'b0;
         vs_act           <= 1'b0;
         rif.h_de         <= 1'b0;
         rif.v_de         <= 1'b0;
         rif.h_pf         <= 1'b0;
         rif.v_pf         <= 1'b0;
         rif.h_pf_pix     <= 1'b0;
      end else begin
         // registered, so x wraps right after h_total
         rif.scanline_end <= rif.x == timing.h_total - 12'd1;
         rif.frame_tick   <= (rif.x == 12'd1) && (rif.y == 12'd1);

         if (rif.x == 12'd1) hs_act <= 1'b1;
         else if (rif.x == timing.h_sync_end) hs_act <= 1'b0;

         if (rif.x == timing.h_de_start) rif.h_de <= 1'b1;
         else if (rif.x == timing.h_de_end) rif.h_de <= 1'b0;

         if (rif.x == timing.h_pf_start) rif.h_pf <= 1'b1;
         else if (rif.x == timing.h_pf_end) rif.h_pf <= 1'b0;

         if (rif.x == timing.h_pf_start - chroni_pkg::pf_prefetch) rif.h_pf_pix <= 1'b1;
         else if (rif.x == timing.h_pf_end - chroni_pkg::pf_prefetch) rif.h_pf_pix <= 1'b0;

         // vertical flags are whole lines
         if (rif.y == 12'd1) vs_act <= 1'b1;
         else if (rif.y == timing.v_sync_end) vs_act <= 1'b0;

         if (rif.y == timing.v_de_start) rif.v_de <= 1'b1;
         else if (rif.y == timing.v_de_end) rif.v_de <= 1'b0;

         if (rif.y == timing.v_pf_start) rif.v_pf <= 1'b1;
         else if (rif.y == timing.v_pf_end) rif.v_pf <= 1'b0;
      end
   end

   assign hs = timing.h_sync_pol ? hs_act : !hs_act;
   assign vs = timing.v_sync_pol ? vs_act : !vs_act;

endmodule

`default_nettype wire

/* source/raster_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface raster_if;
   logic [11:0] x;
   logic [11:0] y;
   logic        h_de;
   logic        v_de;
   logic        h_pf;
   logic        v_pf;
   // playfield window shifted early for buffer reads
   logic        h_pf_pix;
   logic        scanline_end;
   logic        frame_tick;

   modport counter (output x, y, h_de, v_de, h_pf, v_pf, h_pf_pix, scanline_end, frame_tick);
   modport control (input y, scanline_end, frame_tick);
   // read by the pixel path
   modport out (input h_de, v_de, h_pf, v_pf, h_pf_pix, scanline_end);
endinterface

`default_nettype wire

/* source/vga_output.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_output (
   input  logic                  sys_clk,
   input  logic                  vga_clk,
   input  logic                  reset_n,
   input  chroni_pkg::vga_mode_t sys_vga_mode,
   output logic                  vga_hs,
   output logic                  vga_vs,
   output logic [4:0]            vga_r,
   output logic [5:0]            vga_g,
   output logic [4:0]            vga_b,
   output logic                  mode_changed,
   output logic                  frame_start,
   output logic                  render_start,
   output logic                  scanline_start,
   output logic [10:0]           pixel_buffer_index_out,
   output logic                  pixel_scale,
   input  logic                  read_text,
   input  logic                  read_font,
   input  chroni_pkg::pixel_t    pixel,
   input  chroni_pkg::pixel_t    border_color,
   input  logic                  blank_scanline,
   input  logic                  double_pixel
);

   chroni_pkg::vga_mode_t mode_req;
   chroni_pkg::timing_t   timing;
   logic mode_reload;
   logic scale;
   logic double_active;
   logic line_phase;
   logic frame_req, render_req, scanline_req, changed_req;
   logic frame_busy, render_busy, scanline_busy, changed_busy;

   raster_if rif ();

   level_sync #(.payload_t(chroni_pkg::vga_mode_t)) mode_sync (
      .dst_clk(vga_clk), .d(sys_vga_mode), .q(mode_req));

   mode_control control (
      .vga_clk, .reset_n, .mode_req, .double_pixel, .rif(rif.control),
      .timing, .mode_reload, .scale, .double_active, .line_phase,
      .frame_req, .render_req, .scanline_req, .changed_req,
      .frame_busy, .render_busy, .scanline_busy, .changed_busy);

   raster_counter counter (
      .vga_clk, .reset_n, .timing, .mode_reload, .rif(rif.counter),
      .hs(vga_hs), .vs(vga_vs));

   line_output pixels (
      .vga_clk, .reset_n, .rif(rif.out), .scale, .double_active, .line_phase,
      .blank_scanline, .read_text, .read_font, .pixel, .border_color,
      .buffer_index(pixel_buffer_index_out), .r(vga_r), .g(vga_g), .b(vga_b));

   // events into sys_clk
   event_crossing frame_cross (
      .src_clk(vga_clk), .dst_clk(sys_clk), .reset_n,
      .src_req(frame_req), .busy(frame_busy), .pulse(frame_start));

   event_crossing render_cross (
      .src_clk(vga_clk), .dst_clk(sys_clk), .reset_n,
      .src_req(render_req), .busy(render_busy), .pulse(render_start));

   event_crossing scanline_cross (
      .src_clk(vga_clk), .dst_clk(sys_clk), .reset_n,
      .src_req(scanline_req), .busy(scanline_busy), .pulse(scanline_start));

   event_crossing changed_cross (
      .src_clk(vga_clk), .dst_clk(sys_clk), .reset_n,
      .src_req(changed_req), .busy(changed_busy), .pulse(mode_changed));

   level_sync #(.payload_t(logic)) scale_sync (
      .dst_clk(sys_clk), .d(scale), .q(pixel_scale));

endmodule

`default_nettype wire

/* test/vga_output_checks.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_output_checks (
   input  logic                vga_clk, sys_clk, checking, scale,
   input  chroni_pkg::timing_t exp,
   input  logic                hs, vs, read_text, read_font, blank_scanline, double_pixel,
   input  logic [15:0]         rgb,
   input  chroni_pkg::pixel_t  pixel, border_color,
   input  logic [10:0]         index,
   input  logic                frame_start, render_start, scanline_start,
   output logic                failed
);

   // running totals in sys_clk, snapshotted at each vsync edge
   int frames = 0;
   int renders = 0;
   int lines = 0;
   int frames_at, renders_at, lines_at;
   int hx, vy, n, line_start;
   logic hs_a, vs_a;
   logic hs_last = 1'b1;
   logic vs_last = 1'b1;
   logic seen_h, seen_v, line_blank, line_double, v_de, v_pf, in_pf, near_pf;
   chroni_pkg::pixel_t want;

   initial failed = 1'b0;

   task automatic check_value(input string name, input int got, input int expected);
      assert (got == expected) else begin
         if (!failed)
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
         failed = 1'b1;
      end
   endtask

   task automatic check_range(input string name, input int got, input int lo, input int hi);
      assert (got >= lo && got <= hi) else begin
         if (!failed) $display("%s pulse count %0d per frame is outside %0d to %0d",
                               name, got, lo, hi);
         failed = 1'b1;
      end
   endtask

   always @(posedge sys_clk) begin
      frames  <= frames + frame_start;
      renders <= renders + render_start;
      lines   <= lines + scanline_start;
   end

   // hx is 0 on the first active hsync cycle, vy is 0 on the first vsync line
   always @(posedge vga_clk) begin
      hs_a = (hs == exp.h_sync_pol);
      vs_a = (vs == exp.v_sync_pol);
      if (!checking) begin
         seen_h = 1'b0;
         seen_v = 1'b0;
         hs_a   = 1'b1;
         vs_a   = 1'b1;
      end else if (hs_a && !hs_last) begin
         if (seen_h) check_value("hsync period", hx + 1, exp.h_total);
         hx          = 0;
         vy          = vy + 1;
         seen_h      = 1'b1;
         line_blank  = blank_scanline;
         line_double = double_pixel;
         if (vs_a && !vs_last) begin
            if (seen_v) begin
               check_value("vsync period", vy, exp.v_total);
               check_value("frame_start count", frames - frames_at, 1);
               check_value("render_start count", renders - renders_at, 1);
               check_range("scanline_start", lines - lines_at,
                           exp.v_total / 2 - 1, exp.v_total / 2 + 1);
            end
            frames_at  = frames;
            renders_at = renders;
            lines_at   = lines;
            vy         = 0;
            seen_v     = 1'b1;
         end else if (!vs_a && vs_last && seen_v) begin
            check_value("vsync width", vy, exp.v_sync_end - 1);
         end
      end else begin
         hx = hx + 1;
         if (!hs_a && hs_last && seen_h) check_value("hsync width", hx, exp.h_sync_end - 1);
      end

      if (checking && seen_v) begin
         v_de    = vy >= exp.v_de_start - 1 && vy <= exp.v_de_end - 2;
         v_pf    = vy >= exp.v_pf_start - 1 && vy <= exp.v_pf_end - 2;
         in_pf   = v_pf && hx >= exp.h_pf_start && hx <= exp.h_pf_end - 3;
         near_pf = v_pf && hx >= exp.h_pf_start - 2 && hx <= exp.h_pf_end - 1;
         // one cycle of slack at each window edge
         if (!v_de || hx < exp.h_de_start - 2 || hx > exp.h_de_end - 1) begin
            check_value("vga colour", rgb, 0);
         end else if (hx >= exp.h_de_start && hx <= exp.h_de_end - 3 && (in_pf || !near_pf)) begin
            want = (in_pf && !line_blank) ? pixel : border_color;
            if (read_text) want[15:11] = 5'h1f;
            if (read_font) want[10:5] = 6'h3f;
            check_value("vga colour", rgb, want);
         end
         if (v_pf && hx == 10) begin
            n          = vy - (exp.v_pf_start - 1);
            line_start = ((n / (scale ? 4 : 2)) % 2) ? 640 : 0;
            check_value("pixel_buffer_index_out", index, line_start);
         end
         if (v_pf && hx == exp.h_pf_start + 195) begin
            check_value("pixel_buffer_index_out", index,
                        line_start + 200 / ((line_double ? 2 : 1) * (scale ? 2 : 1)));
         end
      end
      hs_last = hs_a;
      vs_last = vs_a;
   end

endmodule

`default_nettype wire

/* test/vga_output_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_output_tb;

   localparam int frame_640 = int'(chroni_pkg::timing_640.h_total) *
                              int'(chroni_pkg::timing_640.v_total);
   localparam int frame_800 = int'(chroni_pkg::timing_800.h_total) *
                              int'(chroni_pkg::timing_800.v_total);
   // up to one frame of waiting at each switch, then 20 lines of 1080
   localparam int run_cycles = 4 * frame_640 + 4 * frame_800 +
                               20 * int'(chroni_pkg::timing_1080.h_total);
   localparam int cycle_limit = run_cycles + run_cycles / 10;

   logic sys_clk, vga_clk, reset_n, checking, scale, failed;
   chroni_pkg::vga_mode_t sys_vga_mode;
   chroni_pkg::timing_t   exp;
   logic vga_hs, vga_vs, mode_changed, frame_start, render_start, scanline_start;
   logic [4:0] vga_r;
   logic [5:0] vga_g;
   logic [4:0] vga_b;
   logic [10:0] pixel_buffer_index_out;
   logic pixel_scale, read_text, read_font, blank_scanline, double_pixel, hs_seen;
   chroni_pkg::pixel_t pixel, border_color;
   logic [31:0] lfsr = 32'h42c2;
   int cycles = 0;
   int changes = 0;

   vga_output UUT (.*);

   vga_output_checks checks (
      .vga_clk, .sys_clk, .checking, .scale, .exp, .hs(vga_hs), .vs(vga_vs), .read_text,
      .read_font, .blank_scanline, .double_pixel, .rgb({vga_r, vga_g, vga_b}), .pixel,
      .border_color, .index(pixel_buffer_index_out), .frame_start, .render_start,
      .scanline_start, .failed);

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // line buffer model, every index bit reaches the colour
   function automatic chroni_pkg::pixel_t buffer_pixel(input logic [10:0] idx);
      return {idx[4:0], idx[10:5], idx[9:5] ^ idx[4:0]};
   endfunction

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic value_error(input string name, input int got, input int expected);
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
      stop_with_failure("final check of the mode switch failed");
   endtask

   task automatic wait_frames(input int count);
      repeat (count) @(posedge frame_start);
   endtask

   task automatic switch_mode(input chroni_pkg::vga_mode_t mode, input chroni_pkg::timing_t t);
      @(negedge sys_clk);
      checking     = 1'b0;
      sys_vga_mode = mode;
      @(posedge mode_changed);
      exp   = t;
      scale = (mode == chroni_pkg::mode_1920x1080);
      @(negedge vga_clk);
      checking = 1'b1;
   endtask

   initial begin
      vga_clk = 1'b0;
      forever #2 vga_clk = ~vga_clk;
   end

   initial begin
      sys_clk = 1'b0;
      forever #3 sys_clk = ~sys_clk;
   end

   // new per-line inputs once per line, as hsync goes inactive
   always @(negedge vga_clk) begin
      pixel   <= buffer_pixel(pixel_buffer_index_out);
      hs_seen <= vga_hs;
      if (vga_hs != hs_seen && vga_hs != exp.h_sync_pol) begin
         lfsr = lfsr_step(lfsr);
         blank_scanline <= lfsr[0];
         lfsr = lfsr_step(lfsr);
         double_pixel <= lfsr[0];
         lfsr = lfsr_step(lfsr);
         read_text <= lfsr[0];
         lfsr = lfsr_step(lfsr);
         read_font <= lfsr[0];
      end
   end

   always @(posedge sys_clk) begin
      if (mode_changed) changes <= changes + 1;
   end

   always @(posedge vga_clk) begin
      cycles <= cycles + 1;
      if (cycles == cycle_limit) stop_with_failure("timeout, the run did not finish in time");
   end

   initial begin
      wait (failed);
      stop_with_failure("a check on the video outputs failed");
   end

   initial begin
      reset_n        = 1'b0;
      checking       = 1'b0;
      scale          = 1'b0;
      exp            = chroni_pkg::timing_640;
      sys_vga_mode   = chroni_pkg::mode_640x480;
      read_text      = 1'b0;
      read_font      = 1'b0;
      blank_scanline = 1'b0;
      double_pixel   = 1'b0;
      hs_seen        = 1'b1;
      pixel          = '0;
      border_color   = 16'h1234;
      repeat (10) @(negedge vga_clk);
      reset_n  = 1'b1;
      checking = 1'b1;
      wait_frames(3);
      switch_mode(chroni_pkg::mode_800x600, chroni_pkg::timing_800);
      wait_frames(3);
      assert (pixel_scale == 1'b0) else value_error("pixel_scale", pixel_scale, 0);
      switch_mode(chroni_pkg::mode_1920x1080, chroni_pkg::timing_1080);
      repeat (20) @(posedge vga_hs);
      assert (pixel_scale == 1'b1) else value_error("pixel_scale", pixel_scale, 1);
      assert (changes == 2) else value_error("mode_changed count", changes, 2);
      if (failed) begin
         stop_with_failure("a check on the video outputs failed");
      end else begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* vga_output.f */
source/chroni_pkg.sv
source/raster_if.sv
source/level_sync.sv
source/event_crossing.sv
source/mode_control.sv
source/raster_counter.sv
source/line_output.sv
source/vga_output.sv
test/vga_output_checks.sv
test/vga_output_tb.sv
